/* rtl/mb_ctrl_pkg.sv */
/*
 * Shared definitions for the motherboard control and status block.
 * Holds the register widths, the APB byte address map, reset values,
 * fixed identification constants and the enums that the APB decoder
 * and the readback mux agree on. Modules import it inside their body.
 */
package mb_ctrl_pkg;

   // ----------------------------------------
   // Widths
   // ----------------------------------------
   localparam int APB_ADDR_W    = 12;
   localparam int DATA_W        = 32;
   localparam int SFP_PIN_W     = 3;
   localparam int SFP_CTRL_W    = 2;
   localparam int MAX_SFP_PORTS = 4;
   localparam int PORT_IDX_W    = $clog2(MAX_SFP_PORTS);
   localparam int LEDS_W        = 2;
   localparam int SW_RST_W      = 4;
   localparam int CLK_CTRL_W    = 8;
   localparam int CLK_STATUS_W  = 8;
   localparam int DEV_ID_W      = 16;

   // ----------------------------------------
   // Address map
   // ----------------------------------------
   localparam logic [APB_ADDR_W-1:0] ADDR_LEDS            = 12'h000;
   localparam logic [APB_ADDR_W-1:0] ADDR_SW_RST          = 12'h004;
   localparam logic [APB_ADDR_W-1:0] ADDR_CLOCK_CTRL      = 12'h008;
   localparam logic [APB_ADDR_W-1:0] ADDR_DEVICE_ID       = 12'h00C;
   localparam logic [APB_ADDR_W-1:0] ADDR_REF_FREQ        = 12'h010;
   localparam logic [APB_ADDR_W-1:0] ADDR_SFP_CTRL_BASE   = 12'h020;
   localparam logic [APB_ADDR_W-1:0] ADDR_COUNTER         = 12'h100;
   localparam logic [APB_ADDR_W-1:0] ADDR_COMPAT          = 12'h104;
   localparam logic [APB_ADDR_W-1:0] ADDR_CLK_STATUS      = 12'h108;
   localparam logic [APB_ADDR_W-1:0] ADDR_DEVICE_INFO     = 12'h10C;
   localparam logic [APB_ADDR_W-1:0] ADDR_SFP_STATUS_BASE = 12'h120;

   // Identification and reset values
   localparam logic [15:0]           COMPAT_MAJOR   = 16'h0026;
   localparam logic [15:0]           COMPAT_MINOR   = 16'h0000;
   localparam logic [15:0]           PROTO_VERSION  = 16'h0100;
   // Bit 6 turns the GPS-disciplined oscillator on
   localparam logic [CLK_CTRL_W-1:0] CLOCK_CTRL_RST = 8'h40;
   localparam logic [DATA_W-1:0]     REF_FREQ_RST   = 32'd10_000_000;

   typedef enum logic [3:0] {
      SEL_NONE, SEL_LEDS, SEL_SW_RST, SEL_CLOCK_CTRL, SEL_DEVICE_ID, SEL_REF_FREQ,
      SEL_SFP_CTRL, SEL_COUNTER, SEL_COMPAT, SEL_CLK_STATUS, SEL_DEVICE_INFO,
      SEL_SFP_STATUS
   } reg_sel_e;

   typedef enum logic [1:0] {
      IDLE,
      SETUP,
      ACCESS
   } apb_state_e;

endpackage

/* rtl/sfp_port_monitor.sv */
/*
 * Status and control for one SFP+ cage.
 * Synchronizes the module-absent, transmit-fault and receive-loss pins,
 * latches any change until the status word is read, and holds the
 * open-drain rate-select bits as drive-low enables.
 */
`timescale 1ns/1ps

module sfp_port_monitor (
   input  logic                                 clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_mod_abs,
   input  logic                                 i_tx_fault,
   input  logic                                 i_rx_los,
   input  logic                                 i_wr,
   input  logic                                 i_rd_clr,
   input  logic [mb_ctrl_pkg::DATA_W-1:0]       i_wdata,
   output logic [mb_ctrl_pkg::SFP_CTRL_W-1:0]   o_rs_drive_low,
   output logic [mb_ctrl_pkg::DATA_W-1:0]       o_status
);
   import mb_ctrl_pkg::*;

   logic [SFP_PIN_W-1:0]  pin_meta;
   logic [SFP_PIN_W-1:0]  pin_sync;
   logic [SFP_PIN_W-1:0]  pin_dly;
   logic [SFP_PIN_W-1:0]  pin_chg;
   logic [SFP_CTRL_W-1:0] rs_bits;

   // ----------------------------------------
   // Pin synchronizers and change latches
   // ----------------------------------------
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         pin_meta <= '0;
         pin_sync <= '0;
         pin_dly  <= '0;
      end else begin
         pin_meta <= {i_mod_abs, i_tx_fault, i_rx_los};
         pin_sync <= pin_meta;
         pin_dly  <= pin_sync;
      end
   end

   // A fresh edge beats a clear in the same cycle
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         pin_chg <= '0;
      else
         pin_chg <= (pin_chg & {SFP_PIN_W{!i_rd_clr}}) | (pin_sync ^ pin_dly);
   end

   // Rate select, 1 pulls the pin low
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         rs_bits <= '0;
      else if (i_wr)
         rs_bits <= i_wdata[SFP_CTRL_W-1:0];
   end

   assign o_rs_drive_low = rs_bits;
   assign o_status       = {{(DATA_W - 2 * SFP_PIN_W){1'b0}}, pin_chg, pin_sync};

   a_chg_sticky: assert property (@(posedge clk) disable iff (!i_rst_n)
      ((~pin_chg & $past(pin_chg)) != '0) |-> $past(i_rd_clr));

endmodule

/* rtl/mb_apb_regs.sv */
/*
 * APB3 slave front end with zero wait states.
 * Decodes the address in the setup cycle, answers in the access cycle,
 * holds the board setting registers and steers strobes to the SFP+
 * monitors and the readback mux.
 */
`timescale 1ns/1ps

module mb_apb_regs #(
   parameter int NUM_SFP_PORTS = 2
) (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_psel,
   input  logic                                  i_penable,
   input  logic                                  i_pwrite,
   input  logic [mb_ctrl_pkg::APB_ADDR_W-1:0]    i_paddr,
   input  logic [mb_ctrl_pkg::DATA_W-1:0]        i_pwdata,
   output logic                                  o_pready,
   output logic                                  o_pslverr,
   output logic [mb_ctrl_pkg::LEDS_W-1:0]        o_leds,
   output logic [mb_ctrl_pkg::SW_RST_W-1:0]      o_sw_rst,
   output logic [mb_ctrl_pkg::CLK_CTRL_W-1:0]    o_clock_control,
   output logic [mb_ctrl_pkg::DEV_ID_W-1:0]      o_device_id,
   output logic [mb_ctrl_pkg::DATA_W-1:0]        o_ref_freq,
   output logic                                  o_ref_freq_changed,
   output mb_ctrl_pkg::reg_sel_e                 o_sel,
   output logic [mb_ctrl_pkg::PORT_IDX_W-1:0]    o_port_idx,
   output logic                                  o_rd_capture,
   output logic [NUM_SFP_PORTS-1:0]              o_sfp_wr,
   output logic [NUM_SFP_PORTS-1:0]              o_sfp_rd_clr,
   output logic [mb_ctrl_pkg::DATA_W-1:0]        o_wdata
);
   import mb_ctrl_pkg::*;

   apb_state_e            state_q;
   apb_state_e            state;
   reg_sel_e              sel_d;
   reg_sel_e              sel_q;
   logic [PORT_IDX_W-1:0] port_d;
   logic [PORT_IDX_W-1:0] port_q;
   logic                  err_q;
   logic                  xfer_ok;

   // ----------------------------------------
   // Bus phase tracking
   // ----------------------------------------
   // Any selected cycle outside ACCESS is a setup cycle
   always_comb begin
      if (state_q == ACCESS)
         state = ACCESS;
      else if (i_psel)
         state = SETUP;
      else
         state = IDLE;
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         state_q <= IDLE;
      else
         state_q <= (state == SETUP) ? ACCESS : IDLE;
   end

   // Address decode, read-only targets rejected for writes
   always_comb begin
      sel_d  = SEL_NONE;
      port_d = '0;
      case (i_paddr)
         ADDR_LEDS:        sel_d = SEL_LEDS;
         ADDR_SW_RST:      sel_d = SEL_SW_RST;
         ADDR_CLOCK_CTRL:  sel_d = SEL_CLOCK_CTRL;
         ADDR_DEVICE_ID:   sel_d = SEL_DEVICE_ID;
         ADDR_REF_FREQ:    sel_d = SEL_REF_FREQ;
         ADDR_COUNTER:     sel_d = SEL_COUNTER;
         ADDR_COMPAT:      sel_d = SEL_COMPAT;
         ADDR_CLK_STATUS:  sel_d = SEL_CLK_STATUS;
         ADDR_DEVICE_INFO: sel_d = SEL_DEVICE_INFO;
         default: begin
            for (int p = 0; p < NUM_SFP_PORTS; p++) begin
               if (i_paddr == APB_ADDR_W'(ADDR_SFP_CTRL_BASE + 4 * p)) begin
                  sel_d  = SEL_SFP_CTRL;
                  port_d = PORT_IDX_W'(p);
               end
               if (i_paddr == APB_ADDR_W'(ADDR_SFP_STATUS_BASE + 4 * p)) begin
                  sel_d  = SEL_SFP_STATUS;
                  port_d = PORT_IDX_W'(p);
               end
            end
         end
      endcase
      if (i_pwrite && (sel_d inside {SEL_COUNTER, SEL_COMPAT, SEL_CLK_STATUS,
                                     SEL_DEVICE_INFO, SEL_SFP_STATUS}))
         sel_d = SEL_NONE;
   end

   always_ff @(posedge clk) begin
      if (state == SETUP) begin
         sel_q  <= sel_d;
         port_q <= port_d;
         err_q  <= (sel_d == SEL_NONE);
      end
   end

   assign xfer_ok      = (state == ACCESS) && !err_q;
   assign o_pready     = (state == ACCESS);
   assign o_pslverr    = (state == ACCESS) && err_q;
   assign o_sel        = sel_d;
   assign o_port_idx   = port_d;
   assign o_rd_capture = (state == SETUP) && !i_pwrite;
   assign o_wdata      = i_pwdata;

   // Per-port strobes, valid in the access cycle only
   always_comb begin
      for (int p = 0; p < NUM_SFP_PORTS; p++) begin
         o_sfp_wr[p]     = xfer_ok && i_pwrite && (sel_q == SEL_SFP_CTRL) &&
                           (port_q == PORT_IDX_W'(p));
         o_sfp_rd_clr[p] = xfer_ok && !i_pwrite && (sel_q == SEL_SFP_STATUS) &&
                           (port_q == PORT_IDX_W'(p));
      end
   end

   // ----------------------------------------
   // Board setting registers
   // ----------------------------------------
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_leds             <= '0;
         o_sw_rst           <= '0;
         o_clock_control    <= CLOCK_CTRL_RST;
         o_device_id        <= '0;
         o_ref_freq         <= REF_FREQ_RST;
         o_ref_freq_changed <= 1'b0;
      end else begin
         o_ref_freq_changed <= 1'b0;
         if (xfer_ok && i_pwrite) begin
            case (sel_q)
               SEL_LEDS:       o_leds          <= i_pwdata[LEDS_W-1:0];
               SEL_SW_RST:     o_sw_rst        <= i_pwdata[SW_RST_W-1:0];
               SEL_CLOCK_CTRL: o_clock_control <= i_pwdata[CLK_CTRL_W-1:0];
               SEL_DEVICE_ID:  o_device_id     <= i_pwdata[DEV_ID_W-1:0];
               SEL_REF_FREQ: begin
                  o_ref_freq         <= i_pwdata;
                  o_ref_freq_changed <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   a_penable_with_psel: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_penable |-> i_psel);

   // Ready only in the cycle straight after a setup
   a_pready_after_setup: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_pready |-> $past(state == SETUP) && i_penable);

endmodule

/* rtl/mb_readback_mux.sv */
/*
 * Read data path for APB reads.
 * Runs the free-running counter and registers the selected word at the
 * end of the setup cycle so that it is stable through the access cycle.
 */
`timescale 1ns/1ps

module mb_readback_mux #(
   parameter int NUM_SFP_PORTS = 2
) (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  mb_ctrl_pkg::reg_sel_e                 i_sel,
   input  logic [mb_ctrl_pkg::PORT_IDX_W-1:0]    i_port_idx,
   input  logic                                  i_rd_capture,
   input  logic [mb_ctrl_pkg::LEDS_W-1:0]        i_leds,
   input  logic [mb_ctrl_pkg::SW_RST_W-1:0]      i_sw_rst,
   input  logic [mb_ctrl_pkg::CLK_CTRL_W-1:0]    i_clock_control,
   input  logic [mb_ctrl_pkg::DEV_ID_W-1:0]      i_device_id,
   input  logic [mb_ctrl_pkg::DATA_W-1:0]        i_ref_freq,
   input  logic [NUM_SFP_PORTS-1:0][mb_ctrl_pkg::SFP_CTRL_W-1:0] i_sfp_ctrl,
   input  logic [mb_ctrl_pkg::CLK_STATUS_W-1:0]  i_clock_status,
   input  logic [NUM_SFP_PORTS-1:0][mb_ctrl_pkg::DATA_W-1:0]     i_sfp_status,
   output logic [mb_ctrl_pkg::DATA_W-1:0]        o_prdata
);
   import mb_ctrl_pkg::*;

   logic [DATA_W-1:0]     counter;
   logic [SFP_CTRL_W-1:0] port_ctrl;
   logic [DATA_W-1:0]     port_status;
   logic [DATA_W-1:0]     rd_word;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         counter <= '0;
      else
         counter <= counter + 1'b1;
   end

   // Pick the addressed SFP+ port
   always_comb begin
      port_ctrl   = '0;
      port_status = '0;
      for (int p = 0; p < NUM_SFP_PORTS; p++) begin
         if (i_port_idx == PORT_IDX_W'(p)) begin
            port_ctrl   = i_sfp_ctrl[p];
            port_status = i_sfp_status[p];
         end
      end
   end

   always_comb begin
      case (i_sel)
         SEL_LEDS:        rd_word = DATA_W'(i_leds);
         SEL_SW_RST:      rd_word = DATA_W'(i_sw_rst);
         SEL_CLOCK_CTRL:  rd_word = DATA_W'(i_clock_control);
         SEL_DEVICE_ID:   rd_word = DATA_W'(i_device_id);
         SEL_REF_FREQ:    rd_word = i_ref_freq;
         SEL_SFP_CTRL:    rd_word = DATA_W'(port_ctrl);
         SEL_COUNTER:     rd_word = counter;
         SEL_COMPAT:      rd_word = {COMPAT_MAJOR, COMPAT_MINOR};
         SEL_CLK_STATUS:  rd_word = DATA_W'(i_clock_status);
         SEL_DEVICE_INFO: rd_word = {i_device_id, PROTO_VERSION};
         SEL_SFP_STATUS:  rd_word = port_status;
         default:         rd_word = '0;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n)
         o_prdata <= '0;
      else if (i_rd_capture)
         o_prdata <= rd_word;
   end

   // Read data holds from one capture to the next
   a_prdata_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
      !$stable(o_prdata) |-> $past(i_rd_capture));

endmodule

/* rtl/mb_ctrl_top.sv */
/*
 * Top level of the motherboard control and status block.
 * The APB decoder owns the board settings, one monitor per SFP+ port
 * tracks pins and rate select, and the readback mux returns read data.
 */
`timescale 1ns/1ps

module mb_ctrl_top #(
   parameter int NUM_SFP_PORTS = 2
) (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   // APB slave
   input  logic                                  i_psel,
   input  logic                                  i_penable,
   input  logic                                  i_pwrite,
   input  logic [mb_ctrl_pkg::APB_ADDR_W-1:0]    i_paddr,
   input  logic [mb_ctrl_pkg::DATA_W-1:0]        i_pwdata,
   output logic [mb_ctrl_pkg::DATA_W-1:0]        o_prdata,
   output logic                                  o_pready,
   output logic                                  o_pslverr,
   // Board status and SFP+ pins
   input  logic [mb_ctrl_pkg::CLK_STATUS_W-1:0]  i_clock_status,
   input  logic [NUM_SFP_PORTS-1:0]              i_sfp_mod_abs,
   input  logic [NUM_SFP_PORTS-1:0]              i_sfp_tx_fault,
   input  logic [NUM_SFP_PORTS-1:0]              i_sfp_rx_los,
   // Board settings
   output logic [mb_ctrl_pkg::LEDS_W-1:0]        o_leds,
   output logic [mb_ctrl_pkg::SW_RST_W-1:0]      o_sw_rst,
   output logic [mb_ctrl_pkg::CLK_CTRL_W-1:0]    o_clock_control,
   output logic [mb_ctrl_pkg::DATA_W-1:0]        o_ref_freq,
   output logic                                  o_ref_freq_changed,
   output logic [NUM_SFP_PORTS-1:0][mb_ctrl_pkg::SFP_CTRL_W-1:0] o_sfp_rs_drive_low
);
   import mb_ctrl_pkg::*;

   reg_sel_e                               sel;
   logic [PORT_IDX_W-1:0]                  port_idx;
   logic                                   rd_capture;
   logic [NUM_SFP_PORTS-1:0]               sfp_wr;
   logic [NUM_SFP_PORTS-1:0]               sfp_rd_clr;
   logic [DATA_W-1:0]                      wdata;
   logic [DEV_ID_W-1:0]                    device_id;
   logic [NUM_SFP_PORTS-1:0][DATA_W-1:0]   sfp_status;

   mb_apb_regs #(
      .NUM_SFP_PORTS (NUM_SFP_PORTS)
   ) u_regs (
      .clk                (clk),
      .i_rst_n            (i_rst_n),
      .i_psel             (i_psel),
      .i_penable          (i_penable),
      .i_pwrite           (i_pwrite),
      .i_paddr            (i_paddr),
      .i_pwdata           (i_pwdata),
      .o_pready           (o_pready),
      .o_pslverr          (o_pslverr),
      .o_leds             (o_leds),
      .o_sw_rst           (o_sw_rst),
      .o_clock_control    (o_clock_control),
      .o_device_id        (device_id),
      .o_ref_freq         (o_ref_freq),
      .o_ref_freq_changed (o_ref_freq_changed),
      .o_sel              (sel),
      .o_port_idx         (port_idx),
      .o_rd_capture       (rd_capture),
      .o_sfp_wr           (sfp_wr),
      .o_sfp_rd_clr       (sfp_rd_clr),
      .o_wdata            (wdata)
   );

   // One monitor per SFP+ cage
   for (genvar p = 0; p < NUM_SFP_PORTS; p++) begin : g_sfp
      sfp_port_monitor u_mon (
         .clk            (clk),
         .i_rst_n        (i_rst_n),
         .i_mod_abs      (i_sfp_mod_abs[p]),
         .i_tx_fault     (i_sfp_tx_fault[p]),
         .i_rx_los       (i_sfp_rx_los[p]),
         .i_wr           (sfp_wr[p]),
         .i_rd_clr       (sfp_rd_clr[p]),
         .i_wdata        (wdata),
         .o_rs_drive_low (o_sfp_rs_drive_low[p]),
         .o_status       (sfp_status[p])
      );
   end

   mb_readback_mux #(
      .NUM_SFP_PORTS (NUM_SFP_PORTS)
   ) u_rb (
      .clk             (clk),
      .i_rst_n         (i_rst_n),
      .i_sel           (sel),
      .i_port_idx      (port_idx),
      .i_rd_capture    (rd_capture),
      .i_leds          (o_leds),
      .i_sw_rst        (o_sw_rst),
      .i_clock_control (o_clock_control),
      .i_device_id     (device_id),
      .i_ref_freq      (o_ref_freq),
      .i_sfp_ctrl      (o_sfp_rs_drive_low),
      .i_clock_status  (i_clock_status),
      .i_sfp_status    (sfp_status),
      .o_prdata        (o_prdata)
   );

endmodule

/* verification/tb_mb_ctrl.sv */
/*
 * Testbench for the motherboard control and status block.
 * Drives APB transfers and SFP+ pin changes into mb_ctrl_top and checks
 * read data, board outputs and the error response with assertions.
 * Run it through run_sim.sh, which compiles project.f with Verilator.
 */
`timescale 1ns/1ps

module tb_mb_ctrl;
   import mb_ctrl_pkg::*;

   localparam int NPORTS     = 2;
   localparam int WAIT_LIMIT = 16;
   localparam int POLL_LIMIT = 12;
   localparam int COUNT_GAP  = 5;

   // Board setting registers in address order and their reset values
   localparam logic [APB_ADDR_W-1:0] SET_ADDR [5] = '{ADDR_LEDS, ADDR_SW_RST,
      ADDR_CLOCK_CTRL, ADDR_DEVICE_ID, ADDR_REF_FREQ};
   localparam logic [DATA_W-1:0] SET_RST [5] = '{32'h0, 32'h0, 32'h40, 32'h0,
      32'd10_000_000};

   logic                                clk;
   logic                                rst_n;
   logic                                psel;
   logic                                penable;
   logic                                pwrite;
   logic [APB_ADDR_W-1:0]               paddr;
   logic [DATA_W-1:0]                   pwdata;
   logic [DATA_W-1:0]                   prdata;
   logic                                pready;
   logic                                pslverr;
   logic [CLK_STATUS_W-1:0]             clock_status;
   logic [NPORTS-1:0]                   sfp_mod_abs;
   logic [NPORTS-1:0]                   sfp_tx_fault;
   logic [NPORTS-1:0]                   sfp_rx_los;
   logic [LEDS_W-1:0]                   leds;
   logic [SW_RST_W-1:0]                 sw_rst;
   logic [CLK_CTRL_W-1:0]               clock_control;
   logic [DATA_W-1:0]                   ref_freq;
   logic                                ref_freq_changed;
   logic [NPORTS-1:0][SFP_CTRL_W-1:0]   sfp_rs_drive_low;

   int                                  errors;
   int                                  timeouts;
   integer                              seed;
   logic [SFP_PIN_W-1:0]                pin_lvl [NPORTS];

   mb_ctrl_top #(
      .NUM_SFP_PORTS (NPORTS)
   ) u_mb_ctrl_top (
      .clk                (clk),
      .i_rst_n            (rst_n),
      .i_psel             (psel),
      .i_penable          (penable),
      .i_pwrite           (pwrite),
      .i_paddr            (paddr),
      .i_pwdata           (pwdata),
      .o_prdata           (prdata),
      .o_pready           (pready),
      .o_pslverr          (pslverr),
      .i_clock_status     (clock_status),
      .i_sfp_mod_abs      (sfp_mod_abs),
      .i_sfp_tx_fault     (sfp_tx_fault),
      .i_sfp_rx_los       (sfp_rx_los),
      .o_leds             (leds),
      .o_sw_rst           (sw_rst),
      .o_clock_control    (clock_control),
      .o_ref_freq         (ref_freq),
      .o_ref_freq_changed (ref_freq_changed),
      .o_sfp_rs_drive_low (sfp_rs_drive_low)
   );

   always #4 clk = ~clk;

   // ----------------------------------------
   // Protocol checks
   // ----------------------------------------
   // Pulse only in the cycle after a reference-frequency write access
   a_ref_freq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      ref_freq_changed == $past(psel && penable && pwrite && (paddr == ADDR_REF_FREQ)))
      else begin
         errors++;
         $display("[FAIL] %0t o_ref_freq_changed out of step with a ref freq write", $time);
      end

   a_slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
      pslverr |-> pready)
      else begin
         errors++;
         $display("[FAIL] %0t o_pslverr high outside an access cycle", $time);
      end

   // ----------------------------------------
   // Helpers
   // ----------------------------------------
   task automatic close_run;
      $display("Checks finished with %0d errors and %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   endtask

   task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] %0t %s: got 0x%08h, expected 0x%08h", $time, what, got, exp);
      end
   endtask

   // Width of each setting register in the address map
   function automatic logic [DATA_W-1:0] reg_mask(input logic [APB_ADDR_W-1:0] addr);
      case (addr)
         ADDR_LEDS:       return 32'h0000_0003;
         ADDR_SW_RST:     return 32'h0000_000f;
         ADDR_CLOCK_CTRL: return 32'h0000_00ff;
         ADDR_DEVICE_ID:  return 32'h0000_ffff;
         default:         return 32'hffff_ffff;
      endcase
   endfunction

   function automatic logic [APB_ADDR_W-1:0] ctrl_addr(input int port);
      return APB_ADDR_W'(ADDR_SFP_CTRL_BASE + 4 * port);
   endfunction

   function automatic logic [APB_ADDR_W-1:0] status_addr(input int port);
      return APB_ADDR_W'(ADDR_SFP_STATUS_BASE + 4 * port);
   endfunction

   // One setup cycle and an access cycle that ends on o_pready
   task automatic apb_xfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, input logic exp_err,
                           output logic [DATA_W-1:0] data);
      int wait_cnt;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      wait_cnt = 0;
      @(negedge clk);
      while (!pready && wait_cnt < WAIT_LIMIT) begin
         wait_cnt++;
         @(negedge clk);
      end
      if (!pready) begin
         timeouts++;
         $display("Timeout: o_pready never rose for address 0x%03h", addr);
      end
      data = prdata;
      assert (pslverr === exp_err) else begin
         errors++;
         $display("[FAIL] %0t o_pslverr %0b at address 0x%03h, expected %0b",
                  $time, pslverr, addr, exp_err);
      end
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic exp_err);
      logic [DATA_W-1:0] ignored;
      apb_xfer(1'b1, addr, wdata, exp_err, ignored);
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, input logic exp_err,
                           output logic [DATA_W-1:0] data);
      apb_xfer(1'b0, addr, '0, exp_err, data);
   endtask

   // Pin 2 is module-absent, 1 transmit-fault, 0 receive-loss
   task automatic drive_pin(input int port, input int pin, input logic level);
      @(posedge clk);
      case (pin)
         2:       sfp_mod_abs[port]  <= level;
         1:       sfp_tx_fault[port] <= level;
         default: sfp_rx_los[port]   <= level;
      endcase
      pin_lvl[port][pin] = level;
   endtask

   task automatic poll_pin_change(input int port, input int pin);
      logic [DATA_W-1:0] exp;
      logic [DATA_W-1:0] got;
      int                polls;
      exp   = DATA_W'({3'(1 << pin), pin_lvl[port]});
      polls = 0;
      apb_read(status_addr(port), 1'b0, got);
      while (got !== exp && polls < POLL_LIMIT) begin
         polls++;
         apb_read(status_addr(port), 1'b0, got);
      end
      if (got !== exp) begin
         timeouts++;
         $display("Timeout: port %0d status never showed the change on pin %0d",
                  port, pin);
      end
      // The read above cleared the latches but kept the levels
      apb_read(status_addr(port), 1'b0, got);
      check_value("SFP status after clear", got, DATA_W'(pin_lvl[port]));
      apb_read(status_addr(1 - port), 1'b0, got);
      check_value("other port change bits", DATA_W'(got[5:3]), '0);
   endtask

   // ----------------------------------------
   // Stimulus
   // ----------------------------------------
   initial begin
      logic [DATA_W-1:0]       data;
      logic [DATA_W-1:0]       got;
      logic [DATA_W-1:0]       cnt_first;
      logic [DATA_W-1:0]       cnt_last;
      logic [DATA_W-1:0]       shadow [5];
      logic [SFP_CTRL_W-1:0]   rs_shadow [NPORTS];
      logic [CLK_STATUS_W-1:0] cs;
      clk          = 1'b0;
      rst_n        = 1'b0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      clock_status = '0;
      sfp_mod_abs  = '0;
      sfp_tx_fault = '0;
      sfp_rx_los   = '0;
      errors       = 0;
      timeouts     = 0;
      seed         = 32'ha68e3a2e;
      foreach (pin_lvl[p])
         pin_lvl[p] = '0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      // Reset values on the outputs and on readback
      @(negedge clk);
      check_value("o_leds after reset", DATA_W'(leds), 32'h0);
      check_value("o_sw_rst after reset", DATA_W'(sw_rst), 32'h0);
      check_value("o_clock_control after reset", DATA_W'(clock_control), 32'h40);
      check_value("o_ref_freq after reset", ref_freq, 32'd10_000_000);
      check_value("o_ref_freq_changed after reset", DATA_W'(ref_freq_changed), 32'h0);
      check_value("drive-low enables after reset", DATA_W'(sfp_rs_drive_low), 32'h0);
      for (int i = 0; i < 5; i++) begin
         apb_read(SET_ADDR[i], 1'b0, got);
         check_value("setting reset readback", got, SET_RST[i]);
      end
      for (int p = 0; p < NPORTS; p++) begin
         apb_read(ctrl_addr(p), 1'b0, got);
         check_value("rate select reset readback", got, 32'h0);
      end

      // Random settings, masked readback and the change pulse
      for (int i = 0; i < 5; i++) begin
         data      = $random(seed);
         shadow[i] = data & reg_mask(SET_ADDR[i]);
         apb_write(SET_ADDR[i], data, 1'b0);
         @(negedge clk);
         if (SET_ADDR[i] == ADDR_REF_FREQ) begin
            check_value("pulse after ref freq write", DATA_W'(ref_freq_changed), 32'h1);
            @(negedge clk);
         end
         check_value("o_ref_freq_changed idle", DATA_W'(ref_freq_changed), 32'h0);
         apb_read(SET_ADDR[i], 1'b0, got);
         check_value("setting readback", got, shadow[i]);
      end
      check_value("o_leds", DATA_W'(leds), shadow[0]);
      check_value("o_sw_rst", DATA_W'(sw_rst), shadow[1]);
      check_value("o_clock_control", DATA_W'(clock_control), shadow[2]);
      check_value("o_ref_freq", ref_freq, shadow[4]);

      // Rate select per port and then a rewrite of port 0 alone
      for (int p = 0; p < NPORTS; p++) begin
         data         = $random(seed);
         rs_shadow[p] = data[SFP_CTRL_W-1:0];
         apb_write(ctrl_addr(p), data, 1'b0);
      end
      // New port 0 value differs from its old value and from port 1
      rs_shadow[0] = rs_shadow[0] + 1'b1;
      if (rs_shadow[0] == rs_shadow[1])
         rs_shadow[0] = rs_shadow[0] + 1'b1;
      apb_write(ctrl_addr(0), DATA_W'(rs_shadow[0]), 1'b0);
      @(negedge clk);
      for (int p = 0; p < NPORTS; p++) begin
         check_value("drive-low enables", DATA_W'(sfp_rs_drive_low[p]), DATA_W'(rs_shadow[p]));
         apb_read(ctrl_addr(p), 1'b0, got);
         check_value("rate select readback", got, DATA_W'(rs_shadow[p]));
      end

      // SFP+ pin changes
      drive_pin(0, 2, 1'b1);
      poll_pin_change(0, 2);
      drive_pin(1, 0, 1'b1);
      poll_pin_change(1, 0);
      drive_pin(0, 2, 1'b0);
      poll_pin_change(0, 2);
      drive_pin(1, 1, 1'b1);
      poll_pin_change(1, 1);

      // Identification, clock status and the free-running counter
      apb_read(ADDR_COMPAT, 1'b0, got);
      check_value("compat number", got, 32'h0026_0000);
      apb_read(ADDR_DEVICE_INFO, 1'b0, got);
      check_value("device info", got, {shadow[3][15:0], 16'h0100});
      cs = CLK_STATUS_W'($random(seed));
      @(posedge clk);
      clock_status <= cs;
      apb_read(ADDR_CLK_STATUS, 1'b0, got);
      check_value("clock status", got, DATA_W'(cs));
      apb_read(ADDR_COUNTER, 1'b0, cnt_first);
      repeat (COUNT_GAP - 1) apb_read(ADDR_COMPAT, 1'b0, got);
      apb_read(ADDR_COUNTER, 1'b0, cnt_last);
      assert (cnt_last - cnt_first >= DATA_W'(2 * COUNT_GAP)) else begin
         errors++;
         $display("[FAIL] %0t counter advanced 0x%08h -> 0x%08h over %0d transfers",
                  $time, cnt_first, cnt_last, COUNT_GAP);
      end

      // Error responses leave every register alone
      apb_read(12'h0FC, 1'b1, got);
      check_value("unmapped read data", got, 32'h0);
      apb_read(ctrl_addr(NPORTS), 1'b1, got);
      check_value("read past last port", got, 32'h0);
      data = $random(seed);
      apb_write(ADDR_COMPAT, data, 1'b1);
      apb_write(ADDR_COUNTER, data, 1'b1);
      apb_write(status_addr(0), data, 1'b1);
      apb_write(12'h014, data, 1'b1);
      apb_write(ctrl_addr(NPORTS), data, 1'b1);
      for (int i = 0; i < 5; i++) begin
         apb_read(SET_ADDR[i], 1'b0, got);
         check_value("setting after bad writes", got, shadow[i]);
      end
      for (int p = 0; p < NPORTS; p++) begin
         apb_read(ctrl_addr(p), 1'b0, got);
         check_value("rate select after bad writes", got, DATA_W'(rs_shadow[p]));
      end
      apb_read(ADDR_COMPAT, 1'b0, got);
      check_value("compat after write attempt", got, 32'h0026_0000);

      close_run();
   end

endmodule

/* project.f */
rtl/mb_ctrl_pkg.sv
rtl/sfp_port_monitor.sv
rtl/mb_apb_regs.sv
rtl/mb_readback_mux.sv
rtl/mb_ctrl_top.sv
verification/tb_mb_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the motherboard control testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module tb_mb_ctrl -o sim_tb_mb_ctrl
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_tb_mb_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Verification failed" "$LOG"; then
   exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
   echo "No result line found in $LOG"
   exit 1
fi
exit 0
